// File: cpuPkg.sv
// shared widths and ALU opcodes for the single-bus datapath
package cpuPkg;

  // bus and register width
  localparam int DataWidth = 32;

  // general register count, R0 through R15
  localparam int NumRegs = 16;

  // ALU opcode width
  localparam int OpWidth = 5;

  // constant field in the low bits of IR, sign-extended onto the bus
  localparam int ConstWidth = 19;

  // ALU opcodes, unlisted values give zero
  localparam logic [OpWidth-1:0] OpAnd = 5'd1;  // Y and bus
  localparam logic [OpWidth-1:0] OpOr  = 5'd2;  // Y or bus
  localparam logic [OpWidth-1:0] OpAdd = 5'd3;  // Y plus bus
  localparam logic [OpWidth-1:0] OpSub = 5'd4;  // Y minus bus
  localparam logic [OpWidth-1:0] OpShr = 5'd5;  // logical right shift of Y
  localparam logic [OpWidth-1:0] OpShl = 5'd6;  // logical left shift of Y
  localparam logic [OpWidth-1:0] OpMul = 5'd7;  // signed 64-bit product
  localparam logic [OpWidth-1:0] OpNeg = 5'd8;  // two's complement of bus
  localparam logic [OpWidth-1:0] OpNot = 5'd9;  // bitwise invert of bus

endpackage

// File: regFile.sv
// sixteen general registers loaded from the shared bus by one-hot enables
`timescale 1ns/1ps

module regFile (
  input  logic                                          Clock,
  input  logic                                          rst,
  input  logic [cpuPkg::NumRegs-1:0]                    regIn,    // one-hot load enables
  input  logic [cpuPkg::DataWidth-1:0]                  busData,
  output logic [cpuPkg::NumRegs*cpuPkg::DataWidth-1:0]  regData   // R0 in the low word
);

  logic [cpuPkg::DataWidth-1:0] regs [cpuPkg::NumRegs];

  // each register watches its own enable bit
  always_ff @(posedge Clock) begin
    if (rst) begin
      for (int i = 0; i < cpuPkg::NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 0; i < cpuPkg::NumRegs; i++) begin
        if (regIn[i]) begin
          regs[i] <= busData;  // bus sampled at the edge
        end
      end
    end
  end

  // flatten the array so the bus multiplexer sees one wide vector
  genvar g;
  generate
    for (g = 0; g < cpuPkg::NumRegs; g++) begin : genFlatten
      assign regData[g*cpuPkg::DataWidth +: cpuPkg::DataWidth] = regs[g];
    end
  endgenerate

endmodule

// File: specialRegs.sv
// PC, IR, MAR, MDR, HI, LO, inport and outport registers of the datapath
`timescale 1ns/1ps

module specialRegs (
  input  logic                          Clock,
  input  logic                          rst,
  input  logic                          pcIn,
  input  logic                          irIn,
  input  logic                          marIn,
  input  logic                          mdrIn,
  input  logic                          hiIn,
  input  logic                          loIn,
  input  logic                          inportIn,
  input  logic                          outportIn,
  input  logic                          read,         // MDR takes memory data when high
  input  logic [cpuPkg::DataWidth-1:0]  busData,
  input  logic [cpuPkg::DataWidth-1:0]  mdrMemIn,
  input  logic [cpuPkg::DataWidth-1:0]  inportData,
  output logic [cpuPkg::DataWidth-1:0]  pcValue,
  output logic [cpuPkg::DataWidth-1:0]  mdrValue,
  output logic [cpuPkg::DataWidth-1:0]  hiValue,
  output logic [cpuPkg::DataWidth-1:0]  loValue,
  output logic [cpuPkg::DataWidth-1:0]  inportValue,
  output logic [cpuPkg::DataWidth-1:0]  constValue,   // sign-extended IR constant
  output logic [cpuPkg::DataWidth-1:0]  memAddr,
  output logic [cpuPkg::DataWidth-1:0]  outportData
);

  logic [cpuPkg::DataWidth-1:0] pcReg;
  logic [cpuPkg::DataWidth-1:0] irReg;
  logic [cpuPkg::DataWidth-1:0] marReg;
  logic [cpuPkg::DataWidth-1:0] mdrReg;
  logic [cpuPkg::DataWidth-1:0] hiReg;
  logic [cpuPkg::DataWidth-1:0] loReg;
  logic [cpuPkg::DataWidth-1:0] inportReg;
  logic [cpuPkg::DataWidth-1:0] outportReg;
  logic [cpuPkg::DataWidth-1:0] mdrNext;

  assign mdrNext = read ? mdrMemIn : busData;  // memory read or bus write-back

  always_ff @(posedge Clock) begin
    if (rst) begin
      pcReg      <= '0;
      irReg      <= '0;
      marReg     <= '0;
      mdrReg     <= '0;
      hiReg      <= '0;
      loReg      <= '0;
      inportReg  <= '0;
      outportReg <= '0;
    end else begin
      if (pcIn)      pcReg      <= busData;
      if (irIn)      irReg      <= busData;
      if (marIn)     marReg     <= busData;
      if (mdrIn)     mdrReg     <= mdrNext;
      if (hiIn)      hiReg      <= busData;
      if (loIn)      loReg      <= busData;
      if (inportIn)  inportReg  <= inportData;  // external input, not the bus
      if (outportIn) outportReg <= busData;
    end
  end

  // the constant field is the only part of IR decoded here
  assign constValue = {{(cpuPkg::DataWidth - cpuPkg::ConstWidth){irReg[cpuPkg::ConstWidth-1]}},
                       irReg[cpuPkg::ConstWidth-1:0]};

  assign pcValue     = pcReg;
  assign mdrValue    = mdrReg;
  assign hiValue     = hiReg;
  assign loValue     = loReg;
  assign inportValue = inportReg;
  assign memAddr     = marReg;      // address lines to memory
  assign outportData = outportReg;  // external output pins

endmodule

// File: alu.sv
// ALU with its Y operand register and 64-bit Z result register
`timescale 1ns/1ps

module alu (
  input  logic                          Clock,
  input  logic                          rst,
  input  logic                          yIn,
  input  logic                          zIn,
  input  logic                          incPc,    // overrides the opcode with bus plus one
  input  logic [cpuPkg::OpWidth-1:0]    opcode,
  input  logic [cpuPkg::DataWidth-1:0]  busData,
  output logic [cpuPkg::DataWidth-1:0]  zHi,
  output logic [cpuPkg::DataWidth-1:0]  zLo
);

  logic [cpuPkg::DataWidth-1:0]           yReg;
  logic [$clog2(cpuPkg::DataWidth)-1:0]   shiftAmt;
  logic signed [2*cpuPkg::DataWidth-1:0]  ySext;
  logic signed [2*cpuPkg::DataWidth-1:0]  bSext;
  logic signed [2*cpuPkg::DataWidth-1:0]  product;
  logic [cpuPkg::DataWidth-1:0]           lowResult;
  logic [cpuPkg::DataWidth-1:0]           pcPlusOne;
  logic [2*cpuPkg::DataWidth-1:0]         aluResult;
  logic [2*cpuPkg::DataWidth-1:0]         zNext;

  // Y holds the first operand while the second is on the bus
  always_ff @(posedge Clock) begin
    if (rst) begin
      yReg <= '0;
    end else if (yIn) begin
      yReg <= busData;
    end
  end

  assign shiftAmt = busData[$clog2(cpuPkg::DataWidth)-1:0];  // low five bits only

  // both operands widened first so the product keeps all 64 bits
  assign ySext   = {{cpuPkg::DataWidth{yReg[cpuPkg::DataWidth-1]}}, yReg};
  assign bSext   = {{cpuPkg::DataWidth{busData[cpuPkg::DataWidth-1]}}, busData};
  assign product = ySext * bSext;

  always_comb begin
    case (opcode)
      cpuPkg::OpAnd: lowResult = yReg & busData;
      cpuPkg::OpOr:  lowResult = yReg | busData;
      cpuPkg::OpAdd: lowResult = yReg + busData;
      cpuPkg::OpSub: lowResult = yReg - busData;
      cpuPkg::OpShr: lowResult = yReg >> shiftAmt;      // zero fill
      cpuPkg::OpShl: lowResult = yReg << shiftAmt;
      cpuPkg::OpNeg: lowResult = '0 - busData;
      cpuPkg::OpNot: lowResult = ~busData;
      default:       lowResult = '0;
    endcase
  end

  // multiply fills both halves while everything else sign-extends into zHi
  always_comb begin
    if (opcode == cpuPkg::OpMul) begin
      aluResult = $unsigned(product);
    end else begin
      aluResult = {{cpuPkg::DataWidth{lowResult[cpuPkg::DataWidth-1]}}, lowResult};
    end
  end

  assign pcPlusOne = busData + {{(cpuPkg::DataWidth-1){1'b0}}, 1'b1};

  assign zNext = incPc ? {{cpuPkg::DataWidth{1'b0}}, pcPlusOne} : aluResult;

  always_ff @(posedge Clock) begin
    if (rst) begin
      zHi <= '0;
      zLo <= '0;
    end else if (zIn) begin
      zHi <= zNext[2*cpuPkg::DataWidth-1:cpuPkg::DataWidth];
      zLo <= zNext[cpuPkg::DataWidth-1:0];
    end
  end

endmodule

// File: busMux.sv
// fixed-priority bus multiplexer driven by the out strobes
`timescale 1ns/1ps

module busMux (
  input  logic [cpuPkg::NumRegs-1:0]                    regOut,
  input  logic                                          zHiOut,
  input  logic                                          zLoOut,
  input  logic                                          pcOut,
  input  logic                                          mdrOut,
  input  logic                                          hiOut,
  input  logic                                          loOut,
  input  logic                                          inportOut,
  input  logic                                          cOut,
  input  logic [cpuPkg::NumRegs*cpuPkg::DataWidth-1:0]  regData,
  input  logic [cpuPkg::DataWidth-1:0]                  zHi,
  input  logic [cpuPkg::DataWidth-1:0]                  zLo,
  input  logic [cpuPkg::DataWidth-1:0]                  pcValue,
  input  logic [cpuPkg::DataWidth-1:0]                  mdrValue,
  input  logic [cpuPkg::DataWidth-1:0]                  hiValue,
  input  logic [cpuPkg::DataWidth-1:0]                  loValue,
  input  logic [cpuPkg::DataWidth-1:0]                  inportValue,
  input  logic [cpuPkg::DataWidth-1:0]                  constValue,
  output logic [cpuPkg::DataWidth-1:0]                  busData
);

  logic [cpuPkg::DataWidth-1:0] regWord;

  // scan downward so the lowest set index is the one that remains
  always_comb begin
    regWord = '0;
    for (int i = cpuPkg::NumRegs - 1; i >= 0; i--) begin
      if (regOut[i]) begin
        regWord = regData[i*cpuPkg::DataWidth +: cpuPkg::DataWidth];
      end
    end
  end

  always_comb begin
    if (zHiOut) begin
      busData = zHi;
    end else if (zLoOut) begin
      busData = zLo;
    end else if (|regOut) begin
      busData = regWord;      // general registers
    end else if (pcOut) begin
      busData = pcValue;
    end else if (mdrOut) begin
      busData = mdrValue;
    end else if (hiOut) begin
      busData = hiValue;
    end else if (loOut) begin
      busData = loValue;
    end else if (inportOut) begin
      busData = inportValue;
    end else if (cOut) begin
      busData = constValue;
    end else begin
      busData = '0;           // idle bus reads as zero
    end
  end

endmodule

// File: dataPath.sv
// single-bus datapath top level joining registers, ALU and bus multiplexer
`timescale 1ns/1ps

module dataPath (
  input  logic                          Clock,
  input  logic                          rst,
  input  logic [cpuPkg::NumRegs-1:0]    regIn,
  input  logic [cpuPkg::NumRegs-1:0]    regOut,
  input  logic                          pcIn,
  input  logic                          irIn,
  input  logic                          marIn,
  input  logic                          mdrIn,
  input  logic                          hiIn,
  input  logic                          loIn,
  input  logic                          inportIn,
  input  logic                          outportIn,
  input  logic                          yIn,
  input  logic                          zIn,
  input  logic                          incPc,
  input  logic                          zHiOut,
  input  logic                          zLoOut,
  input  logic                          pcOut,
  input  logic                          mdrOut,
  input  logic                          hiOut,
  input  logic                          loOut,
  input  logic                          inportOut,
  input  logic                          cOut,
  input  logic                          read,
  input  logic [cpuPkg::OpWidth-1:0]    opcode,
  input  logic [cpuPkg::DataWidth-1:0]  mdrMemIn,
  input  logic [cpuPkg::DataWidth-1:0]  inportData,
  output logic [cpuPkg::DataWidth-1:0]  memAddr,
  output logic [cpuPkg::DataWidth-1:0]  outportData
);

  logic [cpuPkg::DataWidth-1:0]                  busData;  // the one shared bus
  logic [cpuPkg::NumRegs*cpuPkg::DataWidth-1:0]  regData;
  logic [cpuPkg::DataWidth-1:0]                  pcValue;
  logic [cpuPkg::DataWidth-1:0]                  mdrValue;
  logic [cpuPkg::DataWidth-1:0]                  hiValue;
  logic [cpuPkg::DataWidth-1:0]                  loValue;
  logic [cpuPkg::DataWidth-1:0]                  inportValue;
  logic [cpuPkg::DataWidth-1:0]                  constValue;
  logic [cpuPkg::DataWidth-1:0]                  zHi;
  logic [cpuPkg::DataWidth-1:0]                  zLo;

  regFile uRegFile (
    .Clock(Clock), .rst(rst), .regIn(regIn), .busData(busData), .regData(regData)
  );

  specialRegs uSpecialRegs (
    .Clock(Clock), .rst(rst),
    .pcIn(pcIn), .irIn(irIn), .marIn(marIn), .mdrIn(mdrIn),
    .hiIn(hiIn), .loIn(loIn), .inportIn(inportIn), .outportIn(outportIn),
    .read(read), .busData(busData), .mdrMemIn(mdrMemIn), .inportData(inportData),
    .pcValue(pcValue), .mdrValue(mdrValue), .hiValue(hiValue), .loValue(loValue),
    .inportValue(inportValue), .constValue(constValue),
    .memAddr(memAddr), .outportData(outportData)
  );

  alu uAlu (
    .Clock(Clock), .rst(rst), .yIn(yIn), .zIn(zIn), .incPc(incPc),
    .opcode(opcode), .busData(busData), .zHi(zHi), .zLo(zLo)
  );

  busMux uBusMux (
    .regOut(regOut), .zHiOut(zHiOut), .zLoOut(zLoOut), .pcOut(pcOut),
    .mdrOut(mdrOut), .hiOut(hiOut), .loOut(loOut), .inportOut(inportOut), .cOut(cOut),
    .regData(regData), .zHi(zHi), .zLo(zLo), .pcValue(pcValue), .mdrValue(mdrValue),
    .hiValue(hiValue), .loValue(loValue), .inportValue(inportValue),
    .constValue(constValue), .busData(busData)
  );

endmodule

// File: tbDataPath.sv
// control-sequence testbench that steps the single-bus datapath through register transfers
`timescale 1ns/1ps

module tbDataPath;

  logic        Clock;
  logic        rst;
  logic [15:0] regIn;
  logic [15:0] regOut;
  logic        pcIn;
  logic        irIn;
  logic        marIn;
  logic        mdrIn;
  logic        hiIn;
  logic        loIn;
  logic        inportIn;
  logic        outportIn;
  logic        yIn;
  logic        zIn;
  logic        incPc;
  logic        zHiOut;
  logic        zLoOut;
  logic        pcOut;
  logic        mdrOut;
  logic        hiOut;
  logic        loOut;
  logic        inportOut;
  logic        cOut;
  logic        read;
  logic [4:0]  opcode;
  logic [31:0] mdrMemIn;
  logic [31:0] inportData;
  logic [31:0] memAddr;
  logic [31:0] outportData;

  logic [31:0] expRegs [16];  // expected general registers
  int          seed = 40083;
  int          reqCount = 0;
  int          ackCount = 0;
  int          checkWait = 0;
  int          errCount = 0;   // mismatches seen by the compare process
  int          tbErrors = 0;   // stimulus side failures
  int          testCount = 0;
  int          testFails = 0;
  int          errAtStart = 0;
  logic [31:0] checkExp;
  logic [31:0] observed;
  logic        checkMem;       // compare memAddr instead of outportData
  string       checkName;

  dataPath UUT (.*);

  initial begin
    Clock = 1'b0;
    forever #5 Clock = ~Clock;
  end

  // expected 64-bit Z for one ALU step
  function automatic logic [63:0] aluModel(input logic [4:0] op, input logic [31:0] y,
                                           input logic [31:0] b, input logic inc);
    longint      ya;
    longint      yb;
    logic [31:0] lo;
    ya = {{32{y[31]}}, y};
    yb = {{32{b[31]}}, b};
    if (inc) begin
      return {32'd0, b + 32'd1};  // PC increment ignores the opcode
    end
    if (op == cpuPkg::OpMul) begin
      return ya * yb;
    end
    case (op)
      cpuPkg::OpAnd: lo = y & b;
      cpuPkg::OpOr:  lo = y | b;
      cpuPkg::OpAdd: lo = y + b;
      cpuPkg::OpSub: lo = y - b;
      cpuPkg::OpShr: lo = y >> b[4:0];
      cpuPkg::OpShl: lo = y << b[4:0];
      cpuPkg::OpNeg: lo = 32'd0 - b;
      cpuPkg::OpNot: lo = ~b;
      default:       lo = 32'd0;
    endcase
    return {{32{lo[31]}}, lo};
  endfunction

  // compare process that retries each request for up to 20 cycles
  always @(negedge Clock) begin
    if (ackCount != reqCount) begin
      observed = checkMem ? memAddr : outportData;
      if (observed === checkExp) begin
        checkWait = 0;
        ackCount = ackCount + 1;
      end else if (checkWait == 19) begin
        $display("ERR %s expected %h got %h", checkName, checkExp, observed);
        errCount = errCount + 1;
        checkWait = 0;
        ackCount = ackCount + 1;
      end else begin
        checkWait = checkWait + 1;
      end
    end
  end

  task automatic clearStrobes();
    regIn     <= 16'h0;
    regOut    <= 16'h0;
    pcIn      <= 1'b0;
    irIn      <= 1'b0;
    marIn     <= 1'b0;
    mdrIn     <= 1'b0;
    hiIn      <= 1'b0;
    loIn      <= 1'b0;
    inportIn  <= 1'b0;
    outportIn <= 1'b0;
    yIn       <= 1'b0;
    zIn       <= 1'b0;
    incPc     <= 1'b0;
    zHiOut    <= 1'b0;
    zLoOut    <= 1'b0;
    pcOut     <= 1'b0;
    mdrOut    <= 1'b0;
    hiOut     <= 1'b0;
    loOut     <= 1'b0;
    inportOut <= 1'b0;
    cOut      <= 1'b0;
    read      <= 1'b0;
  endtask

  task automatic driveSource(input string src, input logic [3:0] idx);
    case (src)
      "reg":    regOut[idx] <= 1'b1;
      "zhi":    zHiOut <= 1'b1;
      "zlo":    zLoOut <= 1'b1;
      "pc":     pcOut <= 1'b1;
      "mdr":    mdrOut <= 1'b1;
      "hi":     hiOut <= 1'b1;
      "lo":     loOut <= 1'b1;
      "inport": inportOut <= 1'b1;
      "const":  cOut <= 1'b1;
      default: begin
        $display("unknown bus source %s", src);
        tbErrors++;
      end
    endcase
  endtask

  task automatic driveDest(input string dst, input logic [3:0] idx);
    case (dst)
      "reg": regIn[idx] <= 1'b1;
      "pc":  pcIn <= 1'b1;
      "ir":  irIn <= 1'b1;
      "mar": marIn <= 1'b1;
      "mdr": mdrIn <= 1'b1;
      "hi":  hiIn <= 1'b1;
      "lo":  loIn <= 1'b1;
      "out": outportIn <= 1'b1;
      "y":   yIn <= 1'b1;
      default: begin
        $display("unknown bus destination %s", dst);
        tbErrors++;
      end
    endcase
  endtask

  // one bus cycle whose destination loads at the following edge
  task automatic transfer(input string src, input logic [3:0] sIdx,
                          input string dst, input logic [3:0] dIdx);
    @(posedge Clock);
    clearStrobes();
    driveSource(src, sIdx);
    driveDest(dst, dIdx);
  endtask

  task automatic idleCycle();
    @(posedge Clock);
    clearStrobes();
  endtask

  task automatic loadFromMem(input logic [31:0] value, input string dst, input logic [3:0] dIdx);
    @(posedge Clock);
    clearStrobes();
    mdrMemIn <= value;
    read     <= 1'b1;
    mdrIn    <= 1'b1;
    transfer("mdr", 4'd0, dst, dIdx);
    idleCycle();
    if (dst == "reg") begin
      expRegs[dIdx] = value;
    end
  endtask

  // hands one expected value to the compare process and waits for its answer
  task automatic checkPort(input string name, input logic [31:0] exp, input logic useMem);
    int waited;
    checkName = name;
    checkExp  = exp;
    checkMem  = useMem;
    reqCount++;
    waited = 0;
    while (ackCount != reqCount && waited < 24) begin  // just past the compare timeout
      @(posedge Clock);
      waited++;
    end
    if (ackCount != reqCount) begin
      $display("compare of %s got no answer within 24 cycles", name);
      tbErrors++;
      reqCount = ackCount;
    end
  endtask

  task automatic aluOp(input logic [4:0] op, input logic [31:0] a, input logic [31:0] b);
    logic [63:0] model;
    model = aluModel(op, a, b, 1'b0);
    loadFromMem(a, "reg", 4'd2);
    loadFromMem(b, "reg", 4'd3);
    transfer("reg", 4'd2, "y", 4'd0);
    @(posedge Clock);
    clearStrobes();
    regOut[3] <= 1'b1;  // second operand on the bus
    zIn       <= 1'b1;
    opcode    <= op;
    transfer("zlo", 4'd0, "reg", 4'd1);
    transfer("reg", 4'd1, "out", 4'd0);
    idleCycle();
    expRegs[1] = model[31:0];
    checkPort("outportData (zLo)", model[31:0], 1'b0);
    transfer("zhi", 4'd0, "hi", 4'd0);
    transfer("hi", 4'd0, "out", 4'd0);
    idleCycle();
    checkPort("outportData (zHi via HI)", model[63:32], 1'b0);
    if (op == cpuPkg::OpMul) begin
      transfer("zlo", 4'd0, "lo", 4'd0);
      transfer("lo", 4'd0, "out", 4'd0);
      idleCycle();
      checkPort("outportData (zLo via LO)", model[31:0], 1'b0);
    end
  endtask

  task automatic startTest();
    errAtStart = errCount + tbErrors;
  endtask

  task automatic endTest(input string name);
    int fails;
    fails = errCount + tbErrors - errAtStart;
    testCount++;
    if (fails != 0) begin
      testFails++;
    end
    $display("test %s: %s", name, (fails == 0) ? "passed" : "failed");
  endtask

  initial begin
    logic [31:0] value;
    logic [31:0] pcExp;
    logic [63:0] model;
    logic [3:0]  idx;
    rst        = 1'b1;
    opcode     = 5'd0;
    mdrMemIn   = 32'd0;
    inportData = 32'd0;
    clearStrobes();
    for (int r = 0; r < 16; r++) begin
      expRegs[r] = 32'd0;
    end
    repeat (2) @(posedge Clock);
    rst <= 1'b0;

    startTest();
    checkPort("memAddr", 32'd0, 1'b1);
    checkPort("outportData", 32'd0, 1'b0);
    endTest("reset");

    startTest();
    repeat (6) begin
      value = $random(seed);
      idx   = 4'($random(seed));
      loadFromMem(value, "reg", idx);
    end
    for (int r = 0; r < 16; r++) begin
      transfer("reg", 4'(r), "out", 4'd0);
      idleCycle();
      checkPort($sformatf("outportData (R%0d)", r), expRegs[r], 1'b0);
    end
    endTest("memory load");

    for (int op = 0; op <= 10; op++) begin  // 0 and 10 are unused opcodes
      startTest();
      aluOp(5'(op), $random(seed), $random(seed));
      endTest($sformatf("alu opcode %0d", op));
    end

    startTest();
    pcExp     = $random(seed);
    pcExp[31] = 1'b1;  // negative start so a sign-extended zHi would show
    loadFromMem(pcExp, "pc", 4'd0);
    repeat (4) begin
      @(posedge Clock);
      clearStrobes();
      pcOut <= 1'b1;
      incPc <= 1'b1;
      marIn <= 1'b1;
      zIn   <= 1'b1;
      transfer("zlo", 4'd0, "pc", 4'd0);
      idleCycle();
      checkPort("memAddr", pcExp, 1'b1);
      model = aluModel(5'd0, 32'd0, pcExp, 1'b1);
      pcExp = model[31:0];
    end
    transfer("pc", 4'd0, "out", 4'd0);
    idleCycle();
    checkPort("outportData (PC)", pcExp, 1'b0);
    transfer("zhi", 4'd0, "hi", 4'd0);
    transfer("hi", 4'd0, "out", 4'd0);
    idleCycle();
    checkPort("outportData (zHi after increment)", model[63:32], 1'b0);
    endTest("fetch increment");

    startTest();
    for (int k = 0; k < 2; k++) begin
      value     = $random(seed);
      value[18] = k[0];  // both signs of the constant field
      loadFromMem(value, "ir", 4'd0);
      transfer("const", 4'd0, "out", 4'd0);
      idleCycle();
      checkPort("outportData (constant)", {{13{value[18]}}, value[18:0]}, 1'b0);
    end
    endTest("constant");

    startTest();
    value = $random(seed);
    @(posedge Clock);
    clearStrobes();
    inportData <= value;
    inportIn   <= 1'b1;
    transfer("inport", 4'd0, "out", 4'd0);
    idleCycle();
    checkPort("outportData (inport)", value, 1'b0);
    endTest("inport");

    $display("%0d tests, %0d failed, %0d compare errors, %0d other errors",
             testCount, testFails, errCount, tbErrors);
    if (testFails == 0 && errCount == 0 && tbErrors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
cpuPkg.sv
regFile.sv
specialRegs.sv
alu.sv
busMux.sv
dataPath.sv
tbDataPath.sv

// File: Makefile
# Verilator build and run for the single-bus datapath testbench

VERILATOR ?= verilator
TOP       ?= tbDataPath
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= ALL TESTS PASSED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
